//--- Bender.yml
package:
  name: video_timing

sources:
  - include_dirs:
      - .
    files:
      - raster_pkg.sv
      - lcd_pkg.sv
      - raster_scan.sv
      - fb_row_tracker.sv
      - lcd_retimer.sv
      - video_timing_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - video_checker.sv
      - tb_video_timing.sv

//--- fb_row_tracker.sv
// Framebuffer row tracker
`timescale 1ns/10ps
`include "video_defines.svh"

module fb_row_tracker (
    input  logic                clk24,
    input  logic                rst_n_i,
    input  raster_pkg::raster_t raster_i,
    input  logic [7:0]          scroll_i,
    output logic [8:0]          fb_row_o,
    output logic [8:0]          fb_row_count_o
);
    import raster_pkg::*;

    logic load_pt;

    // ------------------------------
    // scroll load point
    // ------------------------------
    // first active line, fixed pixel into the visible area
    assign load_pt = (raster_i.v_state == v_active)
                  && (raster_i.h_state == h_active)
                  && (raster_i.line_y == '0)
                  && (raster_i.pix_x == 10'(`SCROLL_LOAD_X));

    // row pointer walks down the framebuffer one row per raster line
    // remaining row count saturates at zero
    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            fb_row_o       <= '0;
            fb_row_count_o <= '0;
        end
        else if (load_pt)
        begin
            // scroll register addresses pairs of rows, low bit set
            fb_row_o       <= {scroll_i, 1'b1};
            fb_row_count_o <= 9'd511;
        end
        else if (raster_i.line_start)
        begin
            // wraps through 0 to 511
            fb_row_o <= fb_row_o - 9'd1;
            if (fb_row_count_o != '0)
            begin
                fb_row_count_o <= fb_row_count_o - 9'd1;
            end
        end
    end

endmodule

//--- lcd_pkg.sv
// LCD timing types
package lcd_pkg;

    // ------------------------------
    // lcd panel timing word
    // ------------------------------
    // hsync and vsync are active low
    // newline is a single clock strobe at each lcd line wrap
    // row counts visible lcd lines from zero
    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       den;
        logic       newline;
        logic [9:0] row;
    } lcd_t;

endpackage

//--- lcd_retimer.sv
// LCD line re-timer
`timescale 1ns/10ps
`include "video_defines.svh"

module lcd_retimer (
    input  logic                clk24,
    input  logic                rst_n_i,
    input  raster_pkg::raster_t raster_i,
    output lcd_pkg::lcd_t       lcd_o
);
    logic       vsync_q;     // raster vsync, one clock late
    logic       vs_rise;     // end of raster vsync
    logic [4:0] cadence;     // one-hot position in the five line cycle
    logic [9:0] line_len;    // clocks in current lcd line
    logic [9:0] lcd_time;    // clock within lcd line
    logic [9:0] lcd_line;    // lcd lines since vsync
    logic       line_wrap;
    logic       hs_win;
    logic       de_win;
    logic       hsync_q;
    logic       den_q;
    logic       newline_q;
    logic [9:0] row_q;

    assign vs_rise   = raster_i.vsync && !vsync_q;
    assign line_wrap = (lcd_time == line_len - 10'd1);

    // ------------------------------
    // cadence length select
    // ------------------------------
    // 153 and 154 extra clocks dither 768/5
    always_comb
    begin
        case (cadence)
            5'b00010: line_len = 10'(`LCD_BASE + `LCD_EXTRA_1);
            5'b00100: line_len = 10'(`LCD_BASE + `LCD_EXTRA_2);
            5'b01000: line_len = 10'(`LCD_BASE + `LCD_EXTRA_3);
            5'b10000: line_len = 10'(`LCD_BASE + `LCD_EXTRA_4);
            default:  line_len = 10'(`LCD_BASE + `LCD_EXTRA_0);
        endcase
    end

    // line timer, restarted by vsync so every frame starts in phase
    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            vsync_q  <= 1'b1;
            cadence  <= 5'b00001;
            lcd_time <= '0;
            lcd_line <= '0;
        end
        else
        begin
            vsync_q <= raster_i.vsync;
            if (vs_rise)
            begin
                cadence  <= 5'b00001;
                lcd_time <= '0;
                lcd_line <= '0;
            end
            else if (line_wrap)
            begin
                cadence  <= {cadence[3:0], cadence[4]};
                lcd_time <= '0;
                lcd_line <= lcd_line + 10'd1;
            end
            else
            begin
                lcd_time <= lcd_time + 10'd1;
            end
        end
    end

    // ------------------------------
    // lcd sync and enable windows
    // ------------------------------
    assign hs_win = (lcd_time >= 10'(`LCD_HS_START)) && (lcd_time < 10'(`LCD_HS_END));

    // picture window trimmed at the line tail, 480 visible lines
    assign de_win = (lcd_time >= 10'(`LCD_DE_START))
                 && (lcd_time < line_len - 10'(`LCD_DE_TAIL))
                 && (lcd_line >= 10'(`LCD_FIRST_LINE))
                 && (lcd_line < 10'(`LCD_LAST_LINE));

    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            hsync_q   <= 1'b1;
            den_q     <= 1'b0;
            newline_q <= 1'b0;
            row_q     <= '0;
        end
        else
        begin
            // hsync held low through raster vsync
            hsync_q   <= !(hs_win || !raster_i.vsync);
            den_q     <= de_win;
            newline_q <= line_wrap;
            row_q     <= lcd_line - 10'(`LCD_FIRST_LINE);
        end
    end

    // panel vsync follows the raster directly
    always_comb
    begin
        lcd_o.hsync   = hsync_q;
        lcd_o.vsync   = raster_i.vsync;
        lcd_o.den     = den_q;
        lcd_o.newline = newline_q;
        lcd_o.row     = row_q;
    end

endmodule

//--- raster_pkg.sv
// Raster scan types
package raster_pkg;

    // horizontal scan segments, in the order they are walked
    typedef enum logic [2:0] {
        h_front  = 3'd0,
        h_sync   = 3'd1,
        h_back   = 3'd2,
        h_active = 3'd3
    } h_state_e;

    // vertical scan segments
    // pre-sync, sync, back porch, top border, picture, bottom border
    typedef enum logic [2:0] {
        v_pre    = 3'd0,
        v_sync   = 3'd1,
        v_back   = 3'd2,
        v_top    = 3'd3,
        v_active = 3'd4,
        v_bottom = 3'd5
    } v_state_e;

    // raster position and flags, one word per pixel clock
    typedef struct packed {
        h_state_e   h_state;
        v_state_e   v_state;
        logic [9:0] pix_x;        // active pixel index, 0 outside active
        logic [9:0] line_y;       // active line index, 0 outside active
        logic       line_start;   // first clock of front porch
        logic       hsync;        // active low
        logic       vsync;        // active low
        logic       video_active;
        logic       border_y;
        logic       retrace;
    } raster_t;

endpackage

//--- raster_scan.sv
// Raster scan generator
`timescale 1ns/10ps
`include "video_defines.svh"

module raster_scan (
    input  logic                clk24,
    input  logic                rst_n_i,
    output raster_pkg::raster_t raster_o
);
    import raster_pkg::*;

    h_state_e   h_state;
    v_state_e   v_state;
    logic [9:0] h_cnt;      // clocks left in current h segment
    logic [9:0] v_cnt;      // lines left in current v segment
    logic       h_wrap;     // last active clock, front porch follows
    raster_t    raster_d;

    // ------------------------------
    // segment sequencing
    // ------------------------------
    function automatic h_state_e h_next(input h_state_e s);
        case (s)
            h_front: return h_sync;
            h_sync:  return h_back;
            h_back:  return h_active;
            default: return h_front;
        endcase
    endfunction

    // reload value is segment length minus one
    function automatic logic [9:0] h_reload(input h_state_e s);
        case (s)
            h_front: return 10'(`H_FRONT - 1);
            h_sync:  return 10'(`H_SYNC - 1);
            h_back:  return 10'(`H_BACK - 1);
            default: return 10'(`H_ACTIVE - 1);
        endcase
    endfunction

    function automatic v_state_e v_next(input v_state_e s);
        case (s)
            v_pre:    return v_sync;
            v_sync:   return v_back;
            v_back:   return v_top;
            v_top:    return v_active;
            v_active: return v_bottom;
            default:  return v_pre;
        endcase
    endfunction

    function automatic logic [9:0] v_reload(input v_state_e s);
        case (s)
            v_pre:    return 10'(`V_PRE - 1);
            v_sync:   return 10'(`V_SYNC - 1);
            v_back:   return 10'(`V_BACK - 1);
            v_top:    return 10'(`V_TOP - 1);
            v_active: return 10'(`V_ACTIVE - 1);
            default:  return 10'(`V_BOTTOM - 1);
        endcase
    endfunction

    assign h_wrap = (h_state == h_active) && (h_cnt == '0);

    // horizontal machine, one step per pixel clock
    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            h_state <= h_front;
            h_cnt   <= '0;
        end
        else if (h_cnt == '0)
        begin
            h_state <= h_next(h_state);
            h_cnt   <= h_reload(h_next(h_state));
        end
        else
        begin
            h_cnt <= h_cnt - 10'd1;
        end
    end

    // vertical machine steps together with entry into front porch
    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            v_state <= v_pre;
            v_cnt   <= '0;
        end
        else if (h_wrap)
        begin
            if (v_cnt == '0)
            begin
                v_state <= v_next(v_state);
                v_cnt   <= v_reload(v_next(v_state));
            end
            else
            begin
                v_cnt <= v_cnt - 10'd1;
            end
        end
    end

    // ------------------------------
    // flags from counter state
    // ------------------------------
    always_comb
    begin
        raster_d              = '0;
        raster_d.h_state      = h_state;
        raster_d.v_state      = v_state;
        // indices count up while the segment counters count down
        raster_d.pix_x        = (h_state == h_active) ? 10'(`H_ACTIVE - 1) - h_cnt : '0;
        raster_d.line_y       = (v_state == v_active) ? 10'(`V_ACTIVE - 1) - v_cnt : '0;
        raster_d.line_start   = (h_state == h_front) && (h_cnt == 10'(`H_FRONT - 1));
        raster_d.hsync        = (h_state != h_sync);
        raster_d.vsync        = (v_state != v_sync);
        raster_d.video_active = (h_state == h_active) && (v_state == v_active);
        raster_d.border_y     = (v_state == v_top) || (v_state == v_bottom);
        raster_d.retrace      = !((v_state == v_active) || raster_d.border_y);
    end

    // registered outputs, syncs idle high
    always_ff @(posedge clk24 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            raster_o         <= '0;
            raster_o.hsync   <= 1'b1;
            raster_o.vsync   <= 1'b1;
            raster_o.retrace <= 1'b1;
        end
        else
        begin
            raster_o <= raster_d;
        end
    end

endmodule

//--- tb.f
+incdir+.
raster_pkg.sv
lcd_pkg.sv
raster_scan.sv
fb_row_tracker.sv
lcd_retimer.sv
video_timing_top.sv
video_checker.sv
tb_video_timing.sv

//--- tb_video_timing.sv
// Video timing testbench
`timescale 1ns/10ps
`include "video_defines.svh"

module tb_video_timing;
    logic        clk24;
    logic        rst_n_i;
    logic [7:0]  scroll_i;
    logic        hsync_o;
    logic        vsync_o;
    logic        video_active_o;
    logic        border_y_o;
    logic        retrace_o;
    logic [8:0]  fb_row_o;
    logic [8:0]  fb_row_count_o;
    logic        lcd_hsync_o;
    logic        lcd_vsync_o;
    logic        lcd_den_o;
    logic        lcd_newline_o;
    logic [9:0]  lcd_y_o;
    logic [15:0] stim [0:7];
    int unsigned seed;
    int          tb_fail;
    int          mismatch_cnt;
    int          other_cnt;
    int          loads;
    bit          timed_out;

    // 4 ns pixel clock
    initial
    begin
        clk24 = 1'b0;
        forever #2 clk24 = ~clk24;
    end

    video_timing_top dut_i (
        .clk24          (clk24),
        .rst_n_i        (rst_n_i),
        .scroll_i       (scroll_i),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .video_active_o (video_active_o),
        .border_y_o     (border_y_o),
        .retrace_o      (retrace_o),
        .fb_row_o       (fb_row_o),
        .fb_row_count_o (fb_row_count_o),
        .lcd_hsync_o    (lcd_hsync_o),
        .lcd_vsync_o    (lcd_vsync_o),
        .lcd_den_o      (lcd_den_o),
        .lcd_newline_o  (lcd_newline_o),
        .lcd_y_o        (lcd_y_o)
    );

    video_checker u_checker (
        .clk24          (clk24),
        .rst_n_i        (rst_n_i),
        .hsync_i        (hsync_o),
        .vsync_i        (vsync_o),
        .video_active_i (video_active_o),
        .border_y_i     (border_y_o),
        .retrace_i      (retrace_o),
        .fb_row_i       (fb_row_o),
        .fb_row_count_i (fb_row_count_o),
        .lcd_hsync_i    (lcd_hsync_o),
        .lcd_vsync_i    (lcd_vsync_o),
        .lcd_den_i      (lcd_den_o),
        .lcd_newline_i  (lcd_newline_o),
        .lcd_y_i        (lcd_y_o),
        .mismatch_cnt_o (mismatch_cnt),
        .other_cnt_o    (other_cnt),
        .loads_o        (loads)
    );

    // ------------------------------
    // bounded wait for a vsync edge
    // ------------------------------
    task automatic wait_vsync_edge(input bit rising, input int limit);
        int   n;
        bit   seen;
        logic prev;
        n    = 0;
        seen = 0;
        @(posedge clk24);
        prev = vsync_o;
        while (!seen && n < limit)
        begin
            @(posedge clk24);
            seen = rising ? (!prev && vsync_o) : (prev && !vsync_o);
            prev = vsync_o;
            n++;
        end
        if (!seen)
        begin
            $display("timeout: no vsync_o %s edge within %0d clocks",
                     rising ? "rising" : "falling", limit);
            timed_out = 1;
            tb_fail++;
        end
    endtask

    initial
    begin
        int offset;
        rst_n_i   = 1'b0;
        scroll_i  = '0;
        tb_fail   = 0;
        timed_out = 0;
        seed      = 32'h203d9105;
        void'($urandom(seed));
        $readmemh("video_input.txt", stim);
        if (^stim[7] === 1'bx)
        begin
            $display("could not read four frames from video_input.txt");
            tb_fail++;
            timed_out = 1;
        end
        repeat (3) @(posedge clk24);
        #1 rst_n_i = 1'b1;

        // new scroll value somewhere inside each vsync
        for (int f = 0; f < 4 && !timed_out; f++)
        begin
            wait_vsync_edge(1'b0, `V_TOTAL * `H_TOTAL + 1000);
            if (!timed_out)
            begin
                offset = $urandom % 3000;
                repeat (offset) @(posedge clk24);
                #1;
                scroll_i = stim[2 * f][7:0];
                u_checker.push_expected(stim[2 * f + 1][8:0]);
            end
        end
        // let the last frame's checks close before the next scroll load
        if (!timed_out)
            wait_vsync_edge(1'b0, `V_TOTAL * `H_TOTAL + 1000);
        if (!timed_out)
            wait_vsync_edge(1'b1, `V_SYNC * `H_TOTAL + 1000);
        if (!timed_out && loads != 4)
        begin
            $display("expected 4 framebuffer row loads but saw %0d", loads);
            tb_fail++;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + tb_fail);
        if (mismatch_cnt + other_cnt + tb_fail == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- video_checker.sv
// Video timing monitor
`timescale 1ns/10ps
`include "video_defines.svh"

module video_checker (
    input  logic       clk24,
    input  logic       rst_n_i,
    input  logic       hsync_i,
    input  logic       vsync_i,
    input  logic       video_active_i,
    input  logic       border_y_i,
    input  logic       retrace_i,
    input  logic [8:0] fb_row_i,
    input  logic [8:0] fb_row_count_i,
    input  logic       lcd_hsync_i,
    input  logic       lcd_vsync_i,
    input  logic       lcd_den_i,
    input  logic       lcd_newline_i,
    input  logic [9:0] lcd_y_i,
    output int         mismatch_cnt_o,
    output int         other_cnt_o,
    output int         loads_o
);
    int         cyc = 0;
    logic       hs_q = 1'b1;
    logic       vs_q = 1'b1;
    logic       va_q = 1'b0;
    logic [8:0] row_q = '0;
    logic [8:0] cnt_q = '0;
    logic [8:0] exp_q[$];

    // raster line and frame bookkeeping
    int hs_fall_at = -1;
    int vs_fall_at = -1;
    int va_cnt = 0;
    int va_rises = 0;
    int border_lines = 0;
    int active_lines = 0;
    int row_steps = 0;
    bit line_border = 0;
    bit line_retrace = 0;
    bit armed = 0;
    bit wait_load = 0;

    // lcd line bookkeeping
    bit lcd_track = 0;
    bit line_ok = 0;
    int nl_last = 0;
    int lcd_line = 0;
    int hs_low = 0;
    int den_cnt = 0;

    initial
    begin
        mismatch_cnt_o = 0;
        other_cnt_o    = 0;
        loads_o        = 0;
    end

    task automatic mismatch(input string name, input int expv, input int actv);
        $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expv, actv);
        mismatch_cnt_o++;
    endtask

    task automatic failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        other_cnt_o++;
    endtask

    // expected scroll load values, one per frame
    task automatic push_expected(input logic [8:0] v);
        exp_q.push_back(v);
    endtask

    // line length for a cadence position
    function automatic int lcd_len(input int line);
        case (line % 5)
            1:       return `LCD_BASE + `LCD_EXTRA_1;
            2:       return `LCD_BASE + `LCD_EXTRA_2;
            3:       return `LCD_BASE + `LCD_EXTRA_3;
            4:       return `LCD_BASE + `LCD_EXTRA_4;
            default: return `LCD_BASE + `LCD_EXTRA_0;
        endcase
    endfunction

    // ------------------------------
    // raster sync and window checks
    // ------------------------------
    task automatic check_raster();
        bit exp_retrace;
        if (hs_q && !hsync_i)
        begin
            if (hs_fall_at >= 0)
            begin
                if (cyc - hs_fall_at != `H_TOTAL)
                    mismatch("hsync_o period", `H_TOTAL, cyc - hs_fall_at);
                if (va_cnt != 0 && !(va_cnt == `H_ACTIVE && va_rises == 1))
                    mismatch("video_active_o clocks per line", `H_ACTIVE, va_cnt);
                if (va_cnt == `H_ACTIVE)
                    active_lines++;
                if (line_border)
                    border_lines++;
                // retrace on lines that are neither picture nor border
                exp_retrace = !(line_border || va_cnt == `H_ACTIVE);
                if (line_retrace != exp_retrace)
                    mismatch("retrace_o", exp_retrace, line_retrace);
                // one row step per raster line
                if (row_steps != 1)
                    mismatch("fb_row_o steps per line", 1, row_steps);
            end
            hs_fall_at   = cyc;
            va_cnt       = 0;
            va_rises     = 0;
            row_steps    = 0;
            line_border  = border_y_i;
            line_retrace = retrace_i;
        end
        if (!hs_q && hsync_i && hs_fall_at >= 0 && cyc - hs_fall_at != `H_SYNC)
            mismatch("hsync_o low clocks", `H_SYNC, cyc - hs_fall_at);
        if (video_active_i)
            va_cnt++;
        if (video_active_i && !va_q)
            va_rises++;

        if (vs_q && !vsync_i)
        begin
            if (vs_fall_at >= 0)
            begin
                if (cyc - vs_fall_at != `V_TOTAL * `H_TOTAL)
                    mismatch("vsync_o period", `V_TOTAL * `H_TOTAL, cyc - vs_fall_at);
                if (border_lines != `V_TOP + `V_BOTTOM)
                    mismatch("border_y_o lines", `V_TOP + `V_BOTTOM, border_lines);
                if (active_lines != `V_ACTIVE)
                    mismatch("video_active_o lines", `V_ACTIVE, active_lines);
            end
            vs_fall_at   = cyc;
            border_lines = 0;
            active_lines = 0;
            armed        = 1;
        end
        if (!vs_q && vsync_i && vs_fall_at >= 0 && cyc - vs_fall_at != `V_SYNC * `H_TOTAL)
            mismatch("vsync_o low clocks", `V_SYNC * `H_TOTAL, cyc - vs_fall_at);
    endtask

    // ------------------------------
    // framebuffer row checks
    // ------------------------------
    task automatic check_rows();
        logic [8:0] e;
        logic [8:0] exp_cnt;
        if (fb_row_i != row_q || fb_row_count_i != cnt_q)
        begin
            if (wait_load)
            begin
                wait_load = 0;
                loads_o++;
                if (exp_q.size() == 0)
                    failure("fb_row_o reloaded with no expected value queued");
                else
                begin
                    e = exp_q.pop_front();
                    if (fb_row_i != e)
                        mismatch("fb_row_o", e, fb_row_i);
                end
                if (fb_row_count_i != 9'd511)
                    mismatch("fb_row_count_o", 511, fb_row_count_i);
            end
            else
            begin
                // one row down per line, count saturates
                e       = row_q - 9'd1;
                exp_cnt = (cnt_q == '0) ? '0 : cnt_q - 9'd1;
                if (fb_row_i != e)
                    mismatch("fb_row_o", e, fb_row_i);
                if (fb_row_count_i != exp_cnt)
                    mismatch("fb_row_count_o", exp_cnt, fb_row_count_i);
                row_steps++;
            end
        end
        if (armed && video_active_i && !va_q)
        begin
            armed     = 0;
            wait_load = 1;
        end
    endtask

    // ------------------------------
    // lcd cadence and enable checks
    // ------------------------------
    task automatic check_lcd();
        int len;
        int exp_den;
        if (lcd_vsync_i != vsync_i)
            mismatch("lcd_vsync_o", vsync_i, lcd_vsync_i);
        if (!lcd_hsync_i)
            hs_low++;
        if (lcd_den_i)
            den_cnt++;
        if (lcd_track && lcd_den_i && lcd_y_i != 10'(lcd_line - `LCD_FIRST_LINE))
            mismatch("lcd_y_o", lcd_line - `LCD_FIRST_LINE, lcd_y_i);
        if (!vsync_i)
            line_ok = 0;

        // a pulse right after the vsync rise closes the old frame's last line
        if (lcd_newline_i && lcd_track && cyc != nl_last)
        begin
            len = lcd_len(lcd_line);
            if (cyc - nl_last != len)
                mismatch("lcd_newline_o spacing", len, cyc - nl_last);
            if (line_ok && hs_low != `LCD_HS_END - `LCD_HS_START)
                mismatch("lcd_hsync_o low clocks", `LCD_HS_END - `LCD_HS_START, hs_low);
            exp_den = 0;
            if (lcd_line >= `LCD_FIRST_LINE && lcd_line < `LCD_LAST_LINE)
                exp_den = len - `LCD_DE_TAIL - `LCD_DE_START;
            if (den_cnt != exp_den)
                mismatch("lcd_den_o clocks", exp_den, den_cnt);
            nl_last = cyc;
            lcd_line++;
            hs_low  = 0;
            den_cnt = 0;
            line_ok = 1;
        end

        if (!vs_q && vsync_i)
        begin
            lcd_track = 1;
            nl_last   = cyc + 1;
            lcd_line  = 0;
            hs_low    = 0;
            den_cnt   = 0;
            line_ok   = 1;
        end
    endtask

    always @(posedge clk24)
    begin
        cyc++;
        if (!rst_n_i)
        begin
            // idle levels while in reset, once the first reset clock has passed
            if (cyc > 1)
            begin
                if (hsync_i !== 1'b1)
                    mismatch("hsync_o", 1, hsync_i);
                if (vsync_i !== 1'b1)
                    mismatch("vsync_o", 1, vsync_i);
                if (lcd_hsync_i !== 1'b1)
                    mismatch("lcd_hsync_o", 1, lcd_hsync_i);
                if (video_active_i !== 1'b0)
                    mismatch("video_active_o", 0, video_active_i);
                if (lcd_den_i !== 1'b0)
                    mismatch("lcd_den_o", 0, lcd_den_i);
                if (lcd_newline_i !== 1'b0)
                    mismatch("lcd_newline_o", 0, lcd_newline_i);
            end
        end
        else
        begin
            check_raster();
            check_rows();
            check_lcd();
        end
        hs_q  = hsync_i;
        vs_q  = vsync_i;
        va_q  = video_active_i;
        row_q = fb_row_i;
        cnt_q = fb_row_count_i;
    end

endmodule

//--- video_defines.svh
// Video timing constants
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// ------------------------------
// line segments, in pixel clocks
// ------------------------------
`define H_FRONT        11
`define H_SYNC         56
`define H_BACK         61
`define H_ACTIVE       640
`define H_TOTAL        768

// ------------------------------
// frame segments, in lines
// ------------------------------
`define V_PRE          21
`define V_SYNC         5
`define V_BACK         22
`define V_TOP          32
`define V_ACTIVE       512
`define V_BOTTOM       32
`define V_TOTAL        624

// active pixel index on the first active line where scroll is taken
`define SCROLL_LOAD_X  112

// ------------------------------
// lcd line cadence, 5 lcd lines per 6 raster lines
// ------------------------------
`define LCD_BASE       768
`define LCD_EXTRA_0    153
`define LCD_EXTRA_1    154
`define LCD_EXTRA_2    153
`define LCD_EXTRA_3    154
`define LCD_EXTRA_4    154
`define LCD_HS_START   15
`define LCD_HS_END     67

// lcd data enable window
`define LCD_DE_START   67
`define LCD_DE_TAIL    9
`define LCD_FIRST_LINE 23
`define LCD_LAST_LINE  503

`endif

//--- video_input.txt
// one line per frame, in hex
// column 1: scroll value driven during vsync
// column 2: fb_row expected just after the scroll load
5a 0b5
00 001
ff 1ff
37 06f

//--- video_timing_top.sv
// Video timing top level
`timescale 1ns/10ps

module video_timing_top (
    input  logic       clk24,
    input  logic       rst_n_i,
    input  logic [7:0] scroll_i,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       video_active_o,
    output logic       border_y_o,
    output logic       retrace_o,
    output logic [8:0] fb_row_o,
    output logic [8:0] fb_row_count_o,
    output logic       lcd_hsync_o,
    output logic       lcd_vsync_o,
    output logic       lcd_den_o,
    output logic       lcd_newline_o,
    output logic [9:0] lcd_y_o
);
    import raster_pkg::*;
    import lcd_pkg::*;

    raster_t raster_w;
    lcd_t    lcd_w;

    // ------------------------------
    // timing chain
    // ------------------------------
    raster_scan u_raster_scan (
        .clk24    (clk24),
        .rst_n_i  (rst_n_i),
        .raster_o (raster_w)
    );

    fb_row_tracker u_fb_row_tracker (
        .clk24          (clk24),
        .rst_n_i        (rst_n_i),
        .raster_i       (raster_w),
        .scroll_i       (scroll_i),
        .fb_row_o       (fb_row_o),
        .fb_row_count_o (fb_row_count_o)
    );

    lcd_retimer u_lcd_retimer (
        .clk24    (clk24),
        .rst_n_i  (rst_n_i),
        .raster_i (raster_w),
        .lcd_o    (lcd_w)
    );

    // raster outputs
    assign hsync_o        = raster_w.hsync;
    assign vsync_o        = raster_w.vsync;
    assign video_active_o = raster_w.video_active;
    assign border_y_o     = raster_w.border_y;
    assign retrace_o      = raster_w.retrace;

    // lcd outputs
    assign lcd_hsync_o    = lcd_w.hsync;
    assign lcd_vsync_o    = lcd_w.vsync;
    assign lcd_den_o      = lcd_w.den;
    assign lcd_newline_o  = lcd_w.newline;
    assign lcd_y_o        = lcd_w.row;

endmodule
